// ==== compile.f ====
rtl/muldiv_pkg.sv
rtl/seq_pkg.sv
rtl/div_unsigned.sv
rtl/div_signed.sv
rtl/mul_shift_add.sv
rtl/muldiv_unit.sv
test/muldiv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the muldiv testbench with Verilator and runs it
# exits with 0 only when the pass message is found in the output

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module muldiv_tb -f compile.f -o muldiv_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/muldiv_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== test/muldiv_tb.sv ====
`timescale 1ns/1ns

module muldiv_tb
    import muldiv_pkg::*;
();

    localparam int n_rand = 40;
    localparam int n_ops = 8 * n_rand + 8;
    // every operation fits in xlen+4 cycles, plus reset and margin
    localparam int timeout_cycles = n_ops * (xlen + 4) + 5 + 200;
    localparam logic [xlen-1:0] most_neg = {1'b1, {(xlen-1){1'b0}}};

    logic            clk;
    logic            rst_n;
    logic            start;
    muldiv_op_e      op;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic            ready;
    logic            valid;
    logic [xlen-1:0] result;
    logic            div_by_zero;

    logic [31:0] seed;
    int          n_checks;
    int          n_errors;

    muldiv_op_e mul_ops [4] = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
    muldiv_op_e div_ops [4] = '{op_div, op_divu, op_rem, op_remu};

    muldiv_unit i_muldiv_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op         (op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .ready      (ready),
        .valid      (valid),
        .result     (result),
        .div_by_zero(div_by_zero)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // 64-bit model of the M extension rules
    function automatic logic [xlen-1:0] expected_result(muldiv_op_e f_op,
            logic [xlen-1:0] a, logic [xlen-1:0] b);
        logic              sa;
        logic              sb;
        logic [2*xlen-1:0] ea;
        logic [2*xlen-1:0] eb;
        logic [2*xlen-1:0] prod;
        logic [2*xlen-1:0] q;
        logic [2*xlen-1:0] r;
        sa = (f_op inside {op_mulh, op_mulhsu, op_div, op_rem});
        sb = (f_op inside {op_mulh, op_div, op_rem});
        ea = (sa && a[xlen-1]) ? {{xlen{1'b1}}, a} : {{xlen{1'b0}}, a};
        eb = (sb && b[xlen-1]) ? {{xlen{1'b1}}, b} : {{xlen{1'b0}}, b};
        prod = ea * eb;
        if (b == '0) begin
            q = '1;
            r = ea;
        end else if (sa && sb && a == most_neg && b == '1) begin
            q = ea;
            r = '0;
        end else if (sa && sb) begin
            q = $signed(ea) / $signed(eb);
            r = $signed(ea) % $signed(eb);
        end else begin
            q = ea / eb;
            r = ea % eb;
        end
        case (f_op)
            op_mul:                       return prod[xlen-1:0];
            op_mulh, op_mulhsu, op_mulhu: return prod[2*xlen-1:xlen];
            op_div, op_divu:              return q[xlen-1:0];
            default:                      return r[xlen-1:0];
        endcase
    endfunction

    task automatic check_word(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        n_checks++;
        assert (act === exp) else begin
            $display("MISMATCH time %0t %s expected %b actual %b", $time, name, exp, act);
            n_errors++;
        end
    endtask

    task automatic issue_op(muldiv_op_e t_op, logic [xlen-1:0] a, logic [xlen-1:0] b);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        start = 1'b1;
        op = t_op;
        operand_a = a;
        operand_b = b;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_valid();
        while (!valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_op(muldiv_op_e t_op, logic [xlen-1:0] a, logic [xlen-1:0] b);
        logic [xlen-1:0] exp;
        exp = expected_result(t_op, a, b);
        issue_op(t_op, a, b);
        wait_valid();
        check_word($sformatf("result (%s)", t_op.name()), exp, result);
        if (t_op inside {op_div, op_divu, op_rem, op_remu}) begin
            check_bit("div_by_zero", (b == '0), div_by_zero);
        end
        // signed remainder follows the dividend
        if (t_op == op_rem && exp != '0) begin
            check_bit("result sign (op_rem)", a[xlen-1], result[xlen-1]);
        end
    endtask

    task automatic check_reset_state();
        check_bit("ready", 1'b1, ready);
        check_bit("valid", 1'b0, valid);
        repeat (3) begin
            @(posedge clk);
            #1;
            check_bit("valid", 1'b0, valid);
        end
    endtask

    task automatic run_random_multiplies();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        foreach (mul_ops[k]) begin
            for (int i = 0; i < n_rand; i++) begin
                a = next_rand();
                b = next_rand();
                check_op(mul_ops[k], a, b);
            end
        end
    endtask

    task automatic run_random_divides();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [31:0]     shift;
        foreach (div_ops[k]) begin
            for (int i = 0; i < n_rand; i++) begin
                a = next_rand();
                shift = next_rand();
                // shorter divisors give wider quotients
                b = next_rand() >> shift[4:0];
                if (b == '0) begin
                    b = 1;
                end
                check_op(div_ops[k], a, b);
            end
        end
    endtask

    task automatic run_divide_by_zero();
        foreach (div_ops[k]) begin
            check_op(div_ops[k], next_rand(), '0);
        end
    endtask

    task automatic run_signed_overflow();
        check_op(op_div, most_neg, '1);
        check_op(op_rem, most_neg, '1);
    endtask

    task automatic run_handshake();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] exp;
        a = next_rand();
        b = next_rand();
        exp = expected_result(op_mulhu, a, b);
        issue_op(op_mulhu, a, b);
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        n_checks++;
        assert (!ready) else begin
            $display("ready went high at %0t while a multiply was in flight", $time);
            n_errors++;
        end
        // stray divide by zero while busy, must be ignored
        start = 1'b1;
        op = op_divu;
        operand_a = ~a;
        operand_b = '0;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_valid();
        check_word("result (op_mulhu)", exp, result);
        check_bit("div_by_zero", 1'b0, div_by_zero);
        repeat (6) begin
            @(posedge clk);
            #1;
            check_bit("valid", 1'b0, valid);
            check_word("result (held)", exp, result);
        end
    endtask

    initial begin
        seed = 32'd22608;
        n_checks = 0;
        n_errors = 0;
        rst_n = 1'b0;
        start = 1'b0;
        op = op_mul;
        operand_a = '0;
        operand_b = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        run_random_multiplies();
        run_random_divides();
        run_divide_by_zero();
        run_signed_overflow();
        run_handshake();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, valid never arrived", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/1ns

module muldiv_unit
    import muldiv_pkg::*;
    import seq_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  muldiv_op_e      op,
    input  logic [xlen-1:0] operand_a,
    input  logic [xlen-1:0] operand_b,
    output logic            ready,
    output logic            valid,
    output logic [xlen-1:0] result,
    output logic            div_by_zero
);

    seq_state_e state_q;
    muldiv_op_e op_q;
    logic       is_div_q;
    logic       div_by_zero_q;

    logic [xlen-1:0] result_q;
    logic [xlen-1:0] sel_word;

    logic accept;
    logic is_div;
    logic signed_a;
    logic signed_b;
    logic start_mul;
    logic start_div;
    logic sub_valid;

    logic [2*xlen-1:0] product;
    logic              mul_ready;
    logic              mul_valid;
    logic [xlen-1:0]   quotient;
    logic [xlen-1:0]   remainder;
    logic              div_ready;
    logic              div_valid;
    logic              div_error;

    // unit choice and operand signedness
    always_comb begin
        is_div   = 1'b0;
        signed_a = 1'b0;
        signed_b = 1'b0;
        case (op)
            op_mulh: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            op_mulhsu: signed_a = 1'b1;
            op_div, op_rem: begin
                is_div   = 1'b1;
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            op_divu, op_remu: is_div = 1'b1;
            default: ;
        endcase
    end

    assign ready     = (state_q == st_idle) && mul_ready && div_ready;
    assign accept    = start && ready;
    assign start_mul = accept && !is_div;
    assign start_div = accept && is_div;
    assign sub_valid = is_div_q ? div_valid : mul_valid;

    mul_shift_add i_mul_shift_add (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start_mul),
        .signed_a    (signed_a),
        .signed_b    (signed_b),
        .ready       (mul_ready),
        .valid       (mul_valid),
        .multiplicand(operand_a),
        .multiplier  (operand_b),
        .product     (product)
    );

    // div and rem are signed on both operands, so signed_a covers both
    div_signed i_div_signed (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start_div),
        .is_signed(signed_a),
        .ready    (div_ready),
        .valid    (div_valid),
        .error    (div_error),
        .dividend (operand_a),
        .divisor  (operand_b),
        .quotient (quotient),
        .remainder(remainder)
    );

    always_comb begin
        case (op_q)
            op_mul:                       sel_word = product[xlen-1:0];
            op_mulh, op_mulhsu, op_mulhu: sel_word = product[2*xlen-1:xlen];
            op_div, op_divu:              sel_word = quotient;
            default:                      sel_word = remainder;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= st_idle;
            is_div_q      <= 1'b0;
            div_by_zero_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q  <= st_busy;
                        is_div_q <= is_div;
                    end
                end
                st_busy: begin
                    if (sub_valid) begin
                        state_q       <= st_done;
                        div_by_zero_q <= is_div_q && div_error;
                    end
                end
                st_done: state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op;
        end
        if (state_q == st_busy && sub_valid) begin
            result_q <= sel_word;
        end
    end

    assign valid       = (state_q == st_done);
    assign result      = result_q;
    assign div_by_zero = div_by_zero_q;

endmodule

// ==== rtl/mul_shift_add.sv ====
`timescale 1ns/1ns

module mul_shift_add
    import muldiv_pkg::*;
    import seq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              signed_a,
    input  logic              signed_b,
    output logic              ready,
    output logic              valid,
    input  logic [xlen-1:0]   multiplicand,
    input  logic [xlen-1:0]   multiplier,
    output logic [2*xlen-1:0] product
);

    seq_state_e        state_q;
    logic [iter_w-1:0] count_q;
    logic              neg_q;
    logic              last;

    logic a_neg;
    logic b_neg;

    logic [xlen-1:0] mag_a;
    logic [xlen-1:0] mag_b;

    logic [2*xlen-1:0] mcand_q;
    logic [xlen-1:0]   mplier_q;
    logic [2*xlen-1:0] acc_q;

    assign a_neg = signed_a && multiplicand[xlen-1];
    assign b_neg = signed_b && multiplier[xlen-1];
    assign mag_a = a_neg ? -multiplicand : multiplicand;
    assign mag_b = b_neg ? -multiplier : multiplier;

    assign last = (count_q == iter_w'(xlen));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            count_q <= '0;
            neg_q   <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q <= st_busy;
                        count_q <= '0;
                        neg_q   <= a_neg ^ b_neg;
                    end
                end
                st_busy: begin
                    if (last) begin
                        state_q <= st_done;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                st_done: begin
                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && start) begin
            mcand_q  <= {{xlen{1'b0}}, mag_a};
            mplier_q <= mag_b;
            acc_q    <= '0;
        end else if (state_q == st_busy) begin
            if (!last) begin
                // one multiplier bit per cycle, lsb first
                if (mplier_q[0]) begin
                    acc_q <= acc_q + mcand_q;
                end
                mcand_q  <= mcand_q << 1;
                mplier_q <= mplier_q >> 1;
            end else if (neg_q) begin
                // sign fix in the final busy cycle
                acc_q <= -acc_q;
            end
        end
    end

    assign ready   = (state_q == st_idle);
    assign valid   = (state_q == st_done);
    assign product = acc_q;

endmodule

// ==== rtl/div_signed.sv ====
`timescale 1ns/1ns

module div_signed
    import muldiv_pkg::*;
    import seq_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            is_signed,
    output logic            ready,
    output logic            valid,
    output logic            error,
    input  logic [xlen-1:0] dividend,
    input  logic [xlen-1:0] divisor,
    output logic [xlen-1:0] quotient,
    output logic [xlen-1:0] remainder
);

    wrap_state_e state_q;
    logic        quo_neg_q;
    logic        rem_neg_q;

    logic dividend_neg;
    logic divisor_neg;

    logic [xlen-1:0] mag_dividend;
    logic [xlen-1:0] mag_divisor;
    logic [xlen-1:0] mag_quotient;
    logic [xlen-1:0] mag_remainder;

    assign dividend_neg = is_signed && dividend[xlen-1];
    assign divisor_neg  = is_signed && divisor[xlen-1];

    // most negative value maps to itself, which is the right unsigned magnitude
    assign mag_dividend = dividend_neg ? -dividend : dividend;
    assign mag_divisor  = divisor_neg ? -divisor : divisor;

    div_unsigned #(
        .width(xlen)
    ) i_div_unsigned (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .ready    (ready),
        .valid    (valid),
        .error    (error),
        .dividend (mag_dividend),
        .divisor  (mag_divisor),
        .quotient (mag_quotient),
        .remainder(mag_remainder)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= st_wait_idle;
            quo_neg_q <= 1'b0;
            rem_neg_q <= 1'b0;
        end else begin
            case (state_q)
                st_wait_idle: begin
                    if (start && ready) begin
                        state_q   <= st_wait_busy;
                        quo_neg_q <= dividend_neg ^ divisor_neg;
                        rem_neg_q <= dividend_neg;
                    end
                end
                st_wait_busy: begin
                    if (valid) begin
                        state_q <= st_wait_idle;
                    end
                end
                default: begin
                    state_q <= st_wait_idle;
                end
            endcase
        end
    end

    // on divide by zero the quotient stays all ones
    assign quotient  = (!error && quo_neg_q) ? -mag_quotient : mag_quotient;
    assign remainder = rem_neg_q ? -mag_remainder : mag_remainder;

endmodule

// ==== rtl/div_unsigned.sv ====
`timescale 1ns/1ns

module div_unsigned
    import muldiv_pkg::*;
    import seq_pkg::*;
#(
    parameter int width = xlen
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    output logic             ready,
    output logic             valid,
    output logic             error,
    input  logic [width-1:0] dividend,
    input  logic [width-1:0] divisor,
    output logic [width-1:0] quotient,
    output logic [width-1:0] remainder
);

    seq_state_e        state_q;
    logic [iter_w-1:0] count_q;
    logic              zero_q;
    logic              last;

    // quo_q starts as the dividend, quotient bits shift in at the bottom
    logic [width-1:0] quo_q;
    logic [width-1:0] rem_q;
    logic [width-1:0] divisor_q;

    logic [width:0] trial;
    logic [width:0] diff;

    assign last  = (count_q == iter_w'(width));
    assign trial = {rem_q, quo_q[width-1]};
    assign diff  = trial - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            count_q <= '0;
            zero_q  <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (start) begin
                        count_q <= '0;
                        zero_q  <= (divisor == '0);
                        // zero divisor has nothing to iterate
                        state_q <= (divisor == '0) ? st_done : st_busy;
                    end
                end
                st_busy: begin
                    if (last) begin
                        state_q <= st_done;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                st_done: begin
                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && start) begin
            divisor_q <= divisor;
            if (divisor == '0) begin
                quo_q <= '1;
                rem_q <= dividend;
            end else begin
                quo_q <= dividend;
                rem_q <= '0;
            end
        end else if (state_q == st_busy && !last) begin
            // restoring step
            if (!diff[width]) begin
                rem_q <= diff[width-1:0];
                quo_q <= {quo_q[width-2:0], 1'b1};
            end else begin
                rem_q <= trial[width-1:0];
                quo_q <= {quo_q[width-2:0], 1'b0};
            end
        end
    end

    assign ready     = (state_q == st_idle);
    assign valid     = (state_q == st_done);
    assign error     = zero_q;
    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

// ==== rtl/seq_pkg.sv ====
package seq_pkg;

    // iteration counter width, holds 0 to xlen
    localparam int iter_w = 6;

    // multiplier and divider sequencers
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_busy = 2'b01,
        st_done = 2'b10
    } seq_state_e;

    // signed divider wrapper, tracks an outstanding division
    typedef enum logic {
        st_wait_idle = 1'b0,
        st_wait_busy = 1'b1
    } wrap_state_e;

endpackage

// ==== rtl/muldiv_pkg.sv ====
package muldiv_pkg;

    // RV32 operand width
    localparam int xlen = 32;

    // M extension operations, in funct3 order
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } muldiv_op_e;

endpackage
